// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    // 24C16 style device, 2 K bytes
    localparam int ADDR_W    = 11;
    localparam int BLOCK_LSB = 8;   // addr bits 10:8 go in the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // one scl period, low for the first half and high for the second
    localparam int PHASES_PER_BIT = 4;
    localparam int PHASE_W        = $clog2(PHASES_PER_BIT);
    localparam logic [PHASE_W-1:0] PH_DRIVE  = PHASE_W'(0);
    localparam logic [PHASE_W-1:0] PH_RISE   = PHASE_W'(1);
    localparam logic [PHASE_W-1:0] PH_SAMPLE = PHASE_W'(2);
    localparam logic [PHASE_W-1:0] PH_LAST   = PHASE_W'(PHASES_PER_BIT - 1);

    // eight data bits plus the ack slot
    localparam int BITS_PER_BYTE = 9;
    localparam int BIT_W         = $clog2(BITS_PER_BYTE);
    localparam logic [BIT_W-1:0] ACK_BIT = BIT_W'(BITS_PER_BYTE - 1);

    // one-hot state indices of the frame sequencer
    localparam int S_IDLE     = 0;
    localparam int S_START    = 1;
    localparam int S_CTRL_W   = 2;
    localparam int S_ADDR     = 3;
    localparam int S_DATA_W   = 4;
    localparam int S_RSTART   = 5;
    localparam int S_CTRL_R   = 6;
    localparam int S_DATA_R   = 7;
    localparam int S_STOP     = 8;
    localparam int NUM_STATES = 9;

    typedef enum logic [1:0] {
        OP_START,
        OP_WRITE_BYTE,
        OP_READ_BYTE,
        OP_STOP
    } bit_op_e;

    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] block;
        logic       rnw;    // 1 = read
    } ctrl_fields_t;

    typedef union packed {
        logic [7:0]   raw;  // msb first on the wire
        ctrl_fields_t fields;
    } ctrl_byte_u;

endpackage

// ==== rtl/eeprom_if.sv ====
`timescale 1ns/1ps

// pending request, held until take
interface eeprom_req_if;
    import eeprom_pkg::*;

    logic              valid;
    logic              is_read;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              take;

    modport src (output valid, is_read, addr, wdata, input take);
    modport dst (input valid, is_read, addr, wdata, output take);
endinterface

// one bus operation at a time
interface eeprom_bit_if;
    import eeprom_pkg::*;

    logic       go;
    bit_op_e    op;
    logic [7:0] tx_byte;
    logic       done;
    logic [7:0] rx_byte;    // valid with done on a read byte

    modport seq (output go, op, tx_byte, input done, rx_byte);
    modport eng (input go, op, tx_byte, output done, rx_byte);
endinterface

// ==== rtl/eeprom_req_stage.sv ====
`timescale 1ns/1ps

module eeprom_req_stage (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wr_data,
    output logic                          busy,
    eeprom_req_if.src                     req
);
    import eeprom_pkg::*;

    logic              valid;
    logic              accept;
    logic              hold_is_read;
    logic [ADDR_W-1:0] hold_addr;
    logic [7:0]        hold_wdata;

    assign accept = !valid && (wr || rd);  // strobes while full are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            valid <= 1'b0;
        end
        else if (accept)
        begin
            valid <= 1'b1;
        end
        else if (req.take)
        begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            hold_is_read <= !wr;   // wr wins
            hold_addr    <= addr;
            hold_wdata   <= wr_data;
        end
    end

    assign busy        = valid;
    assign req.valid   = valid;
    assign req.is_read = hold_is_read;
    assign req.addr    = hold_addr;
    assign req.wdata   = hold_wdata;

    // a held request only leaves through the sequencer
    a_valid_held: assert property (
        @(posedge CLK) disable iff (RESET)
        req.valid && !req.take |=> req.valid
    ) else $error("request dropped without take");

endmodule

// ==== rtl/eeprom_frame_seq.sv ====
`timescale 1ns/1ps

module eeprom_frame_seq (
    input  logic      CLK,
    input  logic      RESET,
    eeprom_req_if.dst req,
    eeprom_bit_if.seq bit_bus,
    output logic      ack,
    output logic [7:0] rd_data
);
    import eeprom_pkg::*;

    logic [NUM_STATES-1:0] state;
    logic [NUM_STATES-1:0] state_nxt;
    logic                  go_q;
    logic                  op_open;
    bit_op_e               op_sel;
    bit_op_e               op_q;
    logic [7:0]            tx_sel;
    logic [7:0]            tx_q;
    logic                  cur_is_read;
    logic [ADDR_W-1:0]     cur_addr;
    logic [7:0]            cur_wdata;
    logic [7:0]            rx_hold;
    ctrl_byte_u            ctrl_w;
    ctrl_byte_u            ctrl_r;

    function automatic logic [NUM_STATES-1:0] one_hot(input int idx);
        logic [NUM_STATES-1:0] v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    assign req.take = state[S_IDLE] && req.valid;

    always_comb
    begin
        ctrl_w.fields.dev_type = DEV_TYPE;
        ctrl_w.fields.block    = cur_addr[ADDR_W-1:BLOCK_LSB];
        ctrl_w.fields.rnw      = 1'b0;
        ctrl_r                 = ctrl_w;
        ctrl_r.fields.rnw      = 1'b1;
    end

    always_comb
    begin
        state_nxt = state;
        if (state[S_IDLE])
        begin
            if (req.valid)
                state_nxt = one_hot(S_START);
        end
        else if (bit_bus.done)
        begin
            case (1'b1)
                state[S_START]:  state_nxt = one_hot(S_CTRL_W);
                state[S_CTRL_W]: state_nxt = one_hot(S_ADDR);
                state[S_ADDR]:   state_nxt = cur_is_read ? one_hot(S_RSTART) : one_hot(S_DATA_W);
                state[S_DATA_W]: state_nxt = one_hot(S_STOP);
                state[S_RSTART]: state_nxt = one_hot(S_CTRL_R);
                state[S_CTRL_R]: state_nxt = one_hot(S_DATA_R);
                state[S_DATA_R]: state_nxt = one_hot(S_STOP);
                default:         state_nxt = one_hot(S_IDLE);
            endcase
        end
    end

    // operation for the state being entered
    always_comb
    begin
        op_sel = OP_START;
        tx_sel = 8'h00;
        case (1'b1)
            state_nxt[S_CTRL_W]:
            begin
                op_sel = OP_WRITE_BYTE;
                tx_sel = ctrl_w.raw;
            end
            state_nxt[S_ADDR]:
            begin
                op_sel = OP_WRITE_BYTE;
                tx_sel = cur_addr[7:0];
            end
            state_nxt[S_DATA_W]:
            begin
                op_sel = OP_WRITE_BYTE;
                tx_sel = cur_wdata;
            end
            state_nxt[S_CTRL_R]:
            begin
                op_sel = OP_WRITE_BYTE;
                tx_sel = ctrl_r.raw;
            end
            state_nxt[S_DATA_R]: op_sel = OP_READ_BYTE;
            state_nxt[S_STOP]:   op_sel = OP_STOP;
            default:             op_sel = OP_START;  // start and repeated start
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= one_hot(S_IDLE);
            go_q    <= 1'b0;
            op_open <= 1'b0;
            ack     <= 1'b0;
            rd_data <= 8'h00;
        end
        else
        begin
            state   <= state_nxt;
            go_q    <= !state_nxt[S_IDLE] && (state_nxt != state);  // one go per state
            op_open <= go_q || (op_open && !bit_bus.done);
            ack     <= state[S_STOP] && bit_bus.done;
            if (state[S_STOP] && bit_bus.done && cur_is_read)
                rd_data <= rx_hold;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req.take)
        begin
            cur_is_read <= req.is_read;
            cur_addr    <= req.addr;
            cur_wdata   <= req.wdata;
        end
        if (state[S_DATA_R] && bit_bus.done)
            rx_hold <= bit_bus.rx_byte;
        op_q <= op_sel;
        tx_q <= tx_sel;
    end

    assign bit_bus.go      = go_q;
    assign bit_bus.op      = op_q;
    assign bit_bus.tx_byte = tx_q;

    a_go_idle: assert property (
        @(posedge CLK) disable iff (RESET)
        bit_bus.go |-> !op_open
    ) else $error("go issued while an operation is outstanding");

endmodule

// ==== rtl/eeprom_bit_engine.sv ====
`timescale 1ns/1ps

module eeprom_bit_engine (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      sda_in,
    eeprom_bit_if.eng bit_bus,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_oe
);
    import eeprom_pkg::*;

    logic               active;
    bit_op_e            cur_op;
    logic [PHASE_W-1:0] ph;
    logic [BIT_W-1:0]   bit_cnt;
    logic [7:0]         shreg;
    logic               done_q;
    logic               is_byte;
    logic               ack_slot;
    logic               last_bit;

    assign is_byte  = (cur_op == OP_WRITE_BYTE) || (cur_op == OP_READ_BYTE);
    assign ack_slot = (bit_cnt == ACK_BIT);
    assign last_bit = is_byte ? ack_slot : (bit_cnt == '0);

    assign bit_bus.done    = done_q;
    assign bit_bus.rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            cur_op  <= OP_STOP;
            ph      <= '0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!active)
            begin
                if (bit_bus.go)
                begin
                    active  <= 1'b1;
                    cur_op  <= bit_bus.op;
                    ph      <= '0;
                    bit_cnt <= '0;
                end
            end
            else
            begin
                ph <= ph + 1'b1;
                if (ph == PH_RISE)
                    scl <= 1'b1;
                if (ph == PH_LAST)
                begin
                    ph <= '0;
                    if (cur_op != OP_STOP)
                        scl <= 1'b0;   // bus stays high only after stop
                    if (last_bit)
                    begin
                        active <= 1'b0;
                        done_q <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                // sda moves at the end of the first quarter, while scl is low
                case (cur_op)
                    OP_START:
                    begin
                        if (ph == PH_DRIVE)
                        begin
                            sda_oe  <= 1'b1;   // release high first, for repeated start
                            sda_out <= 1'b1;
                        end
                        else if (ph == PH_SAMPLE)
                        begin
                            sda_out <= 1'b0;   // falls with scl high
                        end
                    end
                    OP_STOP:
                    begin
                        if (ph == PH_DRIVE)
                        begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        else if (ph == PH_SAMPLE)
                        begin
                            sda_out <= 1'b1;   // rises with scl high
                        end
                        else if (ph == PH_LAST)
                        begin
                            sda_oe <= 1'b0;
                        end
                    end
                    OP_WRITE_BYTE:
                    begin
                        if (ph == PH_DRIVE)
                        begin
                            sda_oe  <= !ack_slot;  // slave owns the ack slot
                            sda_out <= ack_slot ? sda_out : shreg[7];
                        end
                    end
                    default:
                    begin
                        if (ph == PH_DRIVE)
                        begin
                            sda_oe  <= ack_slot;   // master nack after the read byte
                            sda_out <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && bit_bus.go)
            shreg <= bit_bus.tx_byte;
        else if (active && !ack_slot && ph == PH_DRIVE && cur_op == OP_WRITE_BYTE)
            shreg <= {shreg[6:0], 1'b0};
        else if (active && !ack_slot && ph == PH_SAMPLE && cur_op == OP_READ_BYTE)
            shreg <= {shreg[6:0], sda_in};   // sampled mid scl high
    end

    a_sda_stable: assert property (
        @(posedge CLK) disable iff (RESET)
        active && is_byte && ($changed(sda_out) || $changed(sda_oe)) |-> !scl
    ) else $error("sda changed while scl high during a data bit");

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wr_data,
    input  logic                          sda_in,
    output logic                          scl,
    output logic                          sda_out,
    output logic                          sda_oe,
    output logic                          busy,
    output logic                          ack,
    output logic [7:0]                    rd_data
);

    eeprom_req_if req_bus ();
    eeprom_bit_if bit_bus ();

    eeprom_req_stage req_stage_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .busy    (busy),
        .req     (req_bus.src)
    );

    eeprom_frame_seq frame_seq_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req_bus.dst),
        .bit_bus (bit_bus.seq),
        .ack     (ack),
        .rd_data (rd_data)
    );

    eeprom_bit_engine bit_engine_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .bit_bus (bit_bus.eng),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

endmodule

// ==== dv/eeprom_slave_model.sv ====
`timescale 1ns/1ps

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_low,
    output logic proto_err,
    output int   frames
);
    import eeprom_pkg::*;

    logic [7:0]        mem [0:2**ADDR_W-1];
    logic              scl_q;
    logic              sda_q;
    logic              in_frame;
    logic              seg_rd;     // past the repeated start
    logic              reading;    // model owns sda for data bits
    int                nbytes;
    int                bit_idx;
    logic [7:0]        shreg;
    logic [7:0]        tx;
    logic [7:0]        wbyte;
    logic [ADDR_W-1:0] ptr;
    ctrl_byte_u        ctrl;

    task automatic report_violation(input string what);
        $display("EEPROM model: %s at %0t", what, $time);
        proto_err = 1'b1;
    endtask

    // byte complete, before its ack slot
    task automatic take_byte(input logic [7:0] b);
        ctrl_byte_u cb;
        cb.raw = b;
        if (seg_rd)
        begin
            assert (nbytes == 0 && cb.fields.dev_type == DEV_TYPE && cb.fields.rnw
                    && cb.fields.block == ptr[ADDR_W-1:8])
                else report_violation("bad control byte after the repeated start");
        end
        else
        begin
            case (nbytes)
                0:
                begin
                    assert (cb.fields.dev_type == DEV_TYPE && !cb.fields.rnw)
                        else report_violation("bad control byte at frame start");
                    ctrl = cb;
                end
                1: ptr = {ctrl.fields.block, b};   // block bits from the control byte
                2: wbyte = b;
                default: report_violation("more than three bytes in a write frame");
            endcase
        end
    endtask

    task automatic start_seen();
        if (!in_frame)
        begin
            in_frame = 1'b1;
            seg_rd   = 1'b0;
        end
        else
        begin
            // the rise of the repeated start bit itself counts as one bit
            assert (!seg_rd && nbytes == 2 && bit_idx == 1 && !ctrl.fields.rnw)
                else report_violation("repeated start out of place");
            seg_rd = 1'b1;
        end
        nbytes  = 0;
        bit_idx = 0;
        reading = 1'b0;
    endtask

    task automatic stop_seen();
        assert (in_frame && bit_idx == 1 && nbytes == (seg_rd ? 2 : 3))
            else report_violation("stop without a complete frame");
        if (!seg_rd && nbytes == 3)
            mem[ptr] = wbyte;   // committed on stop
        in_frame = 1'b0;
        sda_low  = 1'b0;
        frames++;
    endtask

    task automatic rise_seen(input logic d);
        assert (in_frame) else report_violation("scl pulse outside a frame");
        if (bit_idx < 8)
        begin
            shreg = {shreg[6:0], d};
            bit_idx++;
        end
        else
        begin
            if (reading)
                assert (d) else report_violation("master acked the read byte");
            nbytes++;
            bit_idx = 0;
        end
    endtask

    task automatic fall_seen();
        if (bit_idx == 8)
        begin
            if (reading)
            begin
                sda_low = 1'b0;   // master nack slot
            end
            else
            begin
                take_byte(shreg);
                sda_low = 1'b1;   // ack every byte
            end
        end
        else if (reading && bit_idx > 0)
        begin
            sda_low = !tx[7 - bit_idx];
        end
        else if (bit_idx == 0)
        begin
            sda_low = 1'b0;
            if (seg_rd && nbytes == 1 && !reading)
            begin
                reading = 1'b1;
                tx      = mem[ptr];
                sda_low = !tx[7];
            end
            else
            begin
                reading = 1'b0;
            end
        end
    endtask

    initial
    begin
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = 8'(i * 7) ^ 8'(i >> 5);
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        sda_low   = 1'b0;
        proto_err = 1'b0;
        frames    = 0;
        in_frame  = 1'b0;
        reading   = 1'b0;
    end

    always @(posedge CLK)
    begin
        logic s;
        logic d;
        #1;
        s = scl;
        d = sda;
        if (RESET)
        begin
            in_frame = 1'b0;
            reading  = 1'b0;
            sda_low  = 1'b0;
        end
        else if (s && scl_q && sda_q && !d)
            start_seen();
        else if (s && scl_q && !sda_q && d)
            stop_seen();
        else if (s && !scl_q)
            rise_seen(d);
        else if (!s && scl_q)
            fall_seen();
        scl_q = s;
        sda_q = d;
    end

endmodule

// ==== dv/eeprom_ctrl_tb.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int MAX_CYCLES = 12000;   // about 60 transactions of up to 170 cycles plus margin

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wr_data;
    logic              sda_in;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    logic              busy;
    logic              ack;
    logic [7:0]        rd_data;
    logic              model_low;
    logic              proto_err;
    int                frames;

    logic [7:0] ref_mem [0:2**ADDR_W-1];
    logic       exp_read [$];
    logic [7:0] exp_data [$];
    logic [7:0] last_rd;
    logic       started;
    int         accepted;
    int         acks;
    int         cycles;
    string      test_name;

    // open-drain line with pull-up
    assign sda_in = !((sda_oe && !sda_out) || model_low);

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .busy    (busy),
        .ack     (ack),
        .rd_data (rd_data)
    );

    eeprom_slave_model slave_model_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_in),
        .sda_low   (model_low),
        .proto_err (proto_err),
        .frames    (frames)
    );

    task automatic abort_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic value_error(input string what, input int expected, input int actual);
        $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
        abort_run("value mismatch");
    endtask

    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    // one-cycle strobe that the request stage takes only when empty
    task automatic strobe(input logic is_read, input logic [ADDR_W-1:0] a,
                          input logic [7:0] d, output logic taken);
        taken   = !busy;
        started = 1'b1;
        wr      = !is_read;
        rd      = is_read;
        addr    = a;
        wr_data = d;
        if (taken)
        begin
            accepted++;
            exp_read.push_back(is_read);
            exp_data.push_back(is_read ? ref_mem[a] : 8'h00);
            if (!is_read)
                ref_mem[a] = d;
        end
        tick();
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic send(input logic is_read, input logic [ADDR_W-1:0] a, input logic [7:0] d);
        logic taken;
        while (busy)
            tick();
        strobe(is_read, a, d, taken);
    endtask

    task automatic drain();
        while (busy || exp_read.size() != 0)
            tick();
    endtask

    initial
    begin
        CLK = 1'b0;
        forever
            #2 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            abort_run("timeout, the run did not finish within the cycle limit");
    end

    always @(posedge CLK)
        assert (!proto_err) else abort_run("the EEPROM model saw a protocol violation");

    // idle state after reset until the first strobe
    always @(posedge CLK)
    begin
        if (!RESET && !started)
        begin
            assert (scl === 1'b1) else value_error("scl idle", 1, int'(scl));
            assert (sda_oe === 1'b0) else value_error("sda_oe idle", 0, int'(sda_oe));
            assert (busy === 1'b0) else value_error("busy idle", 0, int'(busy));
            assert (ack === 1'b0) else value_error("ack idle", 0, int'(ack));
        end
    end

    // acks in request order and read data held between reads
    always @(posedge CLK)
    begin
        if (!RESET && ack)
        begin
            acks++;
            if (exp_read.size() == 0)
            begin
                abort_run("ack pulse with no request outstanding");
            end
            else
            begin
                if (exp_read[0])
                begin
                    assert (rd_data == exp_data[0])
                        else value_error("rd_data", int'(exp_data[0]), int'(rd_data));
                    last_rd = exp_data[0];
                end
                void'(exp_read.pop_front());
                void'(exp_data.pop_front());
            end
        end
        else if (!RESET)
        begin
            assert (rd_data == last_rd)
                else value_error("rd_data hold", int'(last_rd), int'(rd_data));
        end
    end

    initial
    begin
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic [7:0]        low;
        logic              taken;
        int                n;

        void'($urandom(49));
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = 8'h00;
        started   = 1'b0;
        last_rd   = 8'h00;
        accepted  = 0;
        acks      = 0;
        cycles    = 0;
        test_name = "reset";
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (10) tick();

        test_name = "write_read";
        for (int i = 0; i < 20; i++)
        begin
            a = ADDR_W'($urandom);
            d = 8'($urandom);
            send(1'b0, a, d);
            send(1'b1, a, 8'h00);
        end
        drain();

        test_name = "block_alias";
        low = 8'($urandom);
        for (int b = 0; b < 8; b++)
            send(1'b0, {3'(b), low}, 8'(8'(b * 37 + 5) ^ low));
        for (int b = 0; b < 8; b++)
            send(1'b1, {3'(b), low}, 8'h00);
        drain();

        test_name = "overlap";
        a = ADDR_W'($urandom);
        d = 8'($urandom);
        n = acks;
        send(1'b0, a, d);
        while (busy)
            tick();   // first request now on the bus
        strobe(1'b1, a, 8'h00, taken);
        assert (taken && acks == n)
            else abort_run("request refused while the first one was executing");
        send(1'b1, {3'b000, low}, 8'h00);
        drain();

        test_name = "busy_drop";
        a = ADDR_W'($urandom);
        d = 8'($urandom);
        send(1'b0, a, d);
        while (busy)
            tick();
        send(1'b0, a ^ 11'h001, 8'($urandom));   // held pending for a whole frame
        strobe(1'b0, a, ~d, taken);
        assert (!taken) else abort_run("busy was low during the drop test");
        strobe(1'b1, a, 8'h00, taken);
        assert (!taken) else abort_run("busy was low during the drop test");
        drain();
        send(1'b1, a, 8'h00);
        drain();
        repeat (5) tick();

        test_name = "totals";
        if (frames == accepted)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            value_error("frame count", accepted, frames);
        end
    end

endmodule

// ==== flist.f ====
rtl/eeprom_pkg.sv
rtl/eeprom_if.sv
rtl/eeprom_req_stage.sv
rtl/eeprom_frame_seq.sv
rtl/eeprom_bit_engine.sv
rtl/eeprom_ctrl_top.sv
dv/eeprom_slave_model.sv
dv/eeprom_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the EEPROM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module eeprom_ctrl_tb -f flist.f \
    --Mdir obj_dir -o eeprom_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/eeprom_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0
